/* common/dct_pkg.sv */
`default_nettype none

package dct_pkg;

    // data widths
    localparam int PIX_W  = 10;  // signed input sample
    localparam int ROW_W  = 16;  // row coefficient and transpose word
    localparam int OUT_W  = 13;  // final 2d coefficient
    localparam int COEF_W = 16;  // cosine magnitude, sign kept apart

    // block geometry
    localparam int BLK_N  = 8;   // samples per row
    localparam int BLK_SZ = 64;  // samples per block

    // transpose address is {page, row[2:0], col[2:0]}
    localparam int TM_AW  = 7;

    // cosine magnitudes scaled by 2^16
    localparam logic [COEF_W-1:0] C3 = 16'd54491;  // cos(3pi/16)
    localparam logic [COEF_W-1:0] S3 = 16'd36410;  // sin(3pi/16)
    localparam logic [COEF_W-1:0] C4 = 16'd46341;  // cos(pi/4)
    localparam logic [COEF_W-1:0] C6 = 16'd25080;  // cos(6pi/16)
    localparam logic [COEF_W-1:0] S6 = 16'd60547;  // sin(6pi/16)
    localparam logic [COEF_W-1:0] C7 = 16'd12785;  // cos(7pi/16)
    localparam logic [COEF_W-1:0] S7 = 16'd64277;  // sin(7pi/16)

    // row pass product slice and rounding
    localparam int ROW_PROD_LSB = 9;
    localparam int ROW_PROD_W   = 18;
    localparam int ROW_RND_SH   = 3;   // msb of dropped bits rounds half up

    // column pass, wider to keep the row fraction
    localparam int COL_PROD_LSB = 14;
    localparam int COL_PROD_W   = 19;
    localparam int COL_RND_SH   = 8;

    // pipeline latencies in clk cycles
    localparam int DP_LAT        = 7;   // capture strobe to first 1d result
    localparam int ROW_LAT       = 14;  // i_start to first transpose write
    localparam int FIRST_OUT_LAT = 95;  // i_start to first o_dv

endpackage

`default_nettype wire

/* dct_1d/dct_coef_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module dct_coef_rom (
    input  logic                          clk,
    input  logic [2:0]                    i_idx,  // output frequency
    output logic [4*dct_pkg::COEF_W-1:0]  o_mag,  // multiplier j at bits j*COEF_W
    output logic [3:0]                    o_neg   // bit j negates multiplier j
);

    // pair j is x[j] +/- x[7-j], entries are {m3, m2, m1, m0}
    always_ff @(posedge clk) begin
        unique case (i_idx)
            3'd0: begin
                o_mag <= {dct_pkg::C4, dct_pkg::C4, dct_pkg::C4, dct_pkg::C4};  // dc
                o_neg <= 4'b0000;
            end
            3'd1: begin
                o_mag <= {dct_pkg::C7, dct_pkg::S3, dct_pkg::C3, dct_pkg::S7};
                o_neg <= 4'b0000;
            end
            3'd2: begin
                o_mag <= {dct_pkg::S6, dct_pkg::C6, dct_pkg::C6, dct_pkg::S6};
                o_neg <= 4'b1100;
            end
            3'd3: begin
                o_mag <= {dct_pkg::S3, dct_pkg::S7, dct_pkg::C7, dct_pkg::C3};
                o_neg <= 4'b1110;
            end
            3'd4: begin
                o_mag <= {dct_pkg::C4, dct_pkg::C4, dct_pkg::C4, dct_pkg::C4};
                o_neg <= 4'b0110;
            end
            3'd5: begin
                o_mag <= {dct_pkg::C3, dct_pkg::C7, dct_pkg::S7, dct_pkg::S3};
                o_neg <= 4'b0010;
            end
            3'd6: begin
                o_mag <= {dct_pkg::C6, dct_pkg::S6, dct_pkg::S6, dct_pkg::C6};
                o_neg <= 4'b1010;
            end
            3'd7: begin
                o_mag <= {dct_pkg::S7, dct_pkg::C3, dct_pkg::S3, dct_pkg::C7};
                o_neg <= 4'b1010;
            end
        endcase
    end

endmodule

`default_nettype wire

/* dct_1d/dct_1d_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module dct_1d_datapath #(
    parameter  int IN_W     = 10,  // signed sample width
    parameter  int PROD_LSB = 9,   // lsb of the kept product bits
    parameter  int PROD_W   = 18,  // kept product bits
    parameter  int RND_SH   = 3,   // shift before rounding
    localparam int SUM_W    = PROD_W + 2,
    // result never wider than the transpose word
    localparam int Y_W      = (SUM_W - RND_SH > dct_pkg::ROW_W) ? dct_pkg::ROW_W
                                                                 : SUM_W - RND_SH
) (
    input  logic            clk,
    input  logic            i_rst,
    input  logic [IN_W-1:0] i_x,
    input  logic            i_capture,  // i_x holds the eighth sample
    output logic [Y_W-1:0]  o_y         // freq 0..7, DP_LAT after capture
);

    localparam int N   = dct_pkg::BLK_N;
    localparam int A_W = IN_W + 1;               // pair sum or difference
    localparam int M_W = A_W + dct_pkg::COEF_W;  // full product

    logic signed [IN_W-1:0]         sh  [N-1];   // last seven samples, sh[0] newest
    logic signed [IN_W-1:0]         xr  [N];     // latched row, xr[0] oldest
    logic                           toggle;      // 1 adds pairs, 0 subtracts
    logic [2:0]                     idx;         // frequency for the rom
    logic [4*dct_pkg::COEF_W-1:0]   rom_mag;
    logic [3:0]                     rom_neg;
    logic signed [A_W-1:0]          a   [4];     // butterfly out
    logic [A_W-1:0]                 mag [4];
    logic [3:0]                     sgn;
    logic [M_W-1:0]                 prod [4];
    logic [PROD_W-1:0]              pslc [4];    // sliced magnitude
    logic [3:0]                     psgn;        // product sign
    logic signed [PROD_W-1:0]       p   [4];
    logic signed [PROD_W:0]         s01;
    logic signed [PROD_W:0]         s23;
    logic signed [SUM_W-1:0]        sum;

    // seven stage shift plus the live sample make a row
    always_ff @(posedge clk) begin
        sh[0] <= i_x;
        for (int k = 1; k < N - 1; k++) begin
            sh[k] <= sh[k-1];
        end
        if (i_capture) begin
            for (int k = 0; k < N - 1; k++) begin
                xr[k] <= sh[N-2-k];
            end
            xr[N-1] <= i_x;
        end
    end

    // idx starts at 7 so the registered rom gives freq 0 with the first sum
    always_ff @(posedge clk) begin
        if (i_rst) begin
            toggle <= 1'b0;
            idx    <= 3'd0;
        end else if (i_capture) begin
            toggle <= 1'b1;
            idx    <= 3'd7;
        end else begin
            toggle <= ~toggle;  // free running between blocks
            idx    <= idx + 1'b1;
        end
    end

    dct_coef_rom rom_i (
        .clk   (clk),
        .i_idx (idx),
        .o_mag (rom_mag),
        .o_neg (rom_neg)
    );

    always_ff @(posedge clk) begin
        for (int j = 0; j < 4; j++) begin
            if (toggle) begin
                a[j] <= xr[j] + xr[N-1-j];  // even frequencies
            end else begin
                a[j] <= xr[j] - xr[N-1-j];  // odd frequencies
            end
            mag[j]  <= a[j][A_W-1] ? -a[j] : a[j];
            sgn[j]  <= a[j][A_W-1];
            pslc[j] <= prod[j][PROD_LSB +: PROD_W];
            psgn[j] <= sgn[j] ^ rom_neg[j];
            p[j]    <= psgn[j] ? -pslc[j] : pslc[j];
        end
        s01 <= p[0] + p[1];
        s23 <= p[2] + p[3];
        sum <= s01 + s23;
    end

    // unsigned multipliers, rom data lines up with mag
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            prod[j] = mag[j] * rom_mag[j*dct_pkg::COEF_W +: dct_pkg::COEF_W];
        end
    end

    assign o_y = sum[RND_SH +: Y_W] + Y_W'(sum[RND_SH-1]);  // round half up

endmodule

`default_nettype wire

/* rtl/dct_transpose_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module dct_transpose_ram (
    input  logic                      clk,
    input  logic                      i_wr_en,
    input  logic [dct_pkg::TM_AW-1:0] i_wr_addr,  // {page, row, col}
    input  logic [dct_pkg::ROW_W-1:0] i_wr_data,
    input  logic [dct_pkg::TM_AW-1:0] i_rd_addr,
    output logic [dct_pkg::ROW_W-1:0] o_rd_data   // two cycles after i_rd_addr
);

    localparam int DEPTH = 2 ** dct_pkg::TM_AW;  // two pages of 64

    logic [dct_pkg::ROW_W-1:0] mem [DEPTH];
    logic [dct_pkg::TM_AW-1:0] rd_addr_q;        // registered read address

    // write port
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // read port, address reg then output reg
    always_ff @(posedge clk) begin
        rd_addr_q <= i_rd_addr;
        o_rd_data <= mem[rd_addr_q];
    end

endmodule

`default_nettype wire

/* rtl/dct_row_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module dct_row_stage (
    input  logic                      clk,
    input  logic                      i_rst,
    input  logic                      i_start,     // first sample of a block
    input  logic [dct_pkg::PIX_W-1:0] i_pix,
    output logic                      o_last_in,   // sample 63 on i_pix
    output logic                      o_wr_en,
    output logic [dct_pkg::TM_AW-1:0] o_wr_addr,   // {page, row, freq}
    output logic [dct_pkg::ROW_W-1:0] o_wr_data,
    output logic                      o_row_done,  // last write of the block
    output logic                      o_row_page   // page being filled
);

    localparam int CNT_W = $clog2(dct_pkg::BLK_SZ);
    localparam int COL_W = $clog2(dct_pkg::BLK_N);
    localparam logic [CNT_W-1:0] LAST    = CNT_W'(dct_pkg::BLK_SZ - 1);
    localparam logic [COL_W-1:0] ROW_END = COL_W'(dct_pkg::BLK_N - 1);

    logic [CNT_W-1:0]            in_cnt;   // index of the next sample
    logic                        in_act;   // inside a block
    logic                        cur_vld;  // sample on i_pix this cycle
    logic [CNT_W-1:0]            cur_idx;  // its index in the block
    logic                        capture;  // eighth sample of a row
    logic [dct_pkg::ROW_LAT-2:0] st_sr;    // start delay line
    logic                        wr_en;
    logic [dct_pkg::TM_AW-1:0]   wr_addr;  // msb is the page

    always_comb begin
        cur_vld = i_start || in_act;
        cur_idx = i_start ? '0 : in_cnt;                     // start restarts the count
        capture = cur_vld && (cur_idx[COL_W-1:0] == ROW_END);
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            in_cnt    <= '0;
            in_act    <= 1'b0;
            o_last_in <= 1'b0;
            st_sr     <= '0;
            wr_en     <= 1'b0;
            wr_addr   <= '0;
        end else begin
            if (cur_vld) begin
                in_cnt <= cur_idx + 1'b1;
                in_act <= (cur_idx != LAST);                 // stop after sample 63
            end
            o_last_in <= cur_vld && (cur_idx == LAST - 1'b1); // lands on sample 63
            st_sr     <= {st_sr[dct_pkg::ROW_LAT-3:0], i_start};
            // window opens ROW_LAT after start and closes after 64 writes
            wr_en     <= st_sr[dct_pkg::ROW_LAT-2]
                         || (wr_en && (wr_addr[CNT_W-1:0] != LAST));
            if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;                   // carry into msb flips page
            end
        end
    end

    dct_1d_datapath #(
        .IN_W     (dct_pkg::PIX_W),
        .PROD_LSB (dct_pkg::ROW_PROD_LSB),
        .PROD_W   (dct_pkg::ROW_PROD_W),
        .RND_SH   (dct_pkg::ROW_RND_SH)
    ) dp_i (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_x       (i_pix),
        .i_capture (capture),
        .o_y       (o_wr_data)                               // valid DP_LAT after capture
    );

    assign o_wr_en    = wr_en;
    assign o_wr_addr  = wr_addr;
    assign o_row_done = wr_en && (wr_addr[CNT_W-1:0] == LAST);
    assign o_row_page = wr_addr[dct_pkg::TM_AW-1];

    // freq 0 of a row is written DP_LAT after that row was captured
    a_wr_row_aligned: assert property (@(posedge clk) disable iff (i_rst)
        (wr_en && (wr_addr[COL_W-1:0] == '0)) |-> $past(capture, dct_pkg::DP_LAT));

endmodule

`default_nettype wire

/* rtl/dct_col_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module dct_col_stage (
    input  logic                      clk,
    input  logic                      i_rst,
    input  logic                      i_row_done,       // page complete, start reading
    input  logic                      i_row_page,       // valid with i_row_done
    output logic [dct_pkg::TM_AW-1:0] o_rd_addr,
    input  logic [dct_pkg::ROW_W-1:0] i_rd_data,        // two cycles after o_rd_addr
    output logic                      o_pre_first_out,
    output logic                      o_dv,
    output logic [dct_pkg::OUT_W-1:0] o_coef
);

    localparam int RD_LAT  = 2;                                         // ram address+data regs
    localparam int OUT_DLY = RD_LAT + dct_pkg::BLK_N + dct_pkg::DP_LAT; // read to output reg
    localparam int CNT_W   = $clog2(dct_pkg::BLK_SZ);
    localparam int COL_W   = $clog2(dct_pkg::BLK_N);
    localparam logic [CNT_W-1:0] LAST    = CNT_W'(dct_pkg::BLK_SZ - 1);
    localparam logic [COL_W-1:0] COL_END = COL_W'(dct_pkg::BLK_N - 1);

    logic [CNT_W-1:0]          rd_cnt;    // {col, row} read order
    logic                      rd_act;    // read window
    logic                      rd_page;   // page latched at i_row_done
    logic [RD_LAT-1:0]         cap_sr;    // column boundary aligned to ram data
    logic [OUT_DLY-1:0]        dv_sr;     // read window delayed to output
    logic [OUT_DLY-1:0]        pre_sr;    // block start delayed to output
    logic [dct_pkg::OUT_W-1:0] y;         // 1d result before output reg

    always_ff @(posedge clk) begin
        if (i_rst) begin
            rd_cnt  <= '0;
            rd_act  <= 1'b0;
            rd_page <= 1'b0;
            cap_sr  <= '0;
            dv_sr   <= '0;
            pre_sr  <= '0;
        end else begin
            if (i_row_done) begin                      // wins over the end of the last block
                rd_cnt  <= '0;
                rd_act  <= 1'b1;
                rd_page <= i_row_page;
            end else if (rd_act) begin
                rd_cnt <= rd_cnt + 1'b1;
                rd_act <= (rd_cnt != LAST);
            end
            cap_sr <= {cap_sr[RD_LAT-2:0], rd_act && (rd_cnt[COL_W-1:0] == COL_END)};
            dv_sr  <= {dv_sr[OUT_DLY-2:0], rd_act};
            pre_sr <= {pre_sr[OUT_DLY-2:0], i_row_done};
        end
    end

    // transposed address, low count bits select the row
    assign o_rd_addr = {rd_page, rd_cnt[COL_W-1:0], rd_cnt[CNT_W-1:COL_W]};

    dct_1d_datapath #(
        .IN_W     (dct_pkg::ROW_W),
        .PROD_LSB (dct_pkg::COL_PROD_LSB),
        .PROD_W   (dct_pkg::COL_PROD_W),
        .RND_SH   (dct_pkg::COL_RND_SH)
    ) dp_i (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_x       (i_rd_data),
        .i_capture (cap_sr[RD_LAT-1]),  // last row of a column on i_rd_data
        .o_y       (y)
    );

    // output reg, loads one cycle ahead of o_dv
    always_ff @(posedge clk) begin
        if (dv_sr[OUT_DLY-2]) begin
            o_coef <= y;
        end
    end

    assign o_dv            = dv_sr[OUT_DLY-1];
    assign o_pre_first_out = pre_sr[OUT_DLY-1];

    // each output run is announced a cycle early
    a_dv_announced: assert property (@(posedge clk) disable iff (i_rst)
        $rose(o_dv) |-> $past(o_pre_first_out));

endmodule

`default_nettype wire

/* rtl/dct8x8_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dct8x8_top (
    input  logic                      clk,
    input  logic                      i_rst,
    input  logic                      i_start,          // goes with sample 0
    input  logic [dct_pkg::PIX_W-1:0] i_pix,
    output logic                      o_last_in,        // sample 63 on input
    output logic                      o_pre_first_out,  // one cycle before o_dv
    output logic                      o_dv,
    output logic [dct_pkg::OUT_W-1:0] o_coef
);

    logic                      tm_we;      // row pass writes
    logic [dct_pkg::TM_AW-1:0] tm_wa;
    logic [dct_pkg::ROW_W-1:0] tm_wd;
    logic [dct_pkg::TM_AW-1:0] tm_ra;      // column pass reads
    logic [dct_pkg::ROW_W-1:0] tm_rd;
    logic                      row_done;   // last write of a block
    logic                      row_page;   // page being filled

    dct_row_stage row_i (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_start    (i_start),
        .i_pix      (i_pix),
        .o_last_in  (o_last_in),
        .o_wr_en    (tm_we),
        .o_wr_addr  (tm_wa),
        .o_wr_data  (tm_wd),
        .o_row_done (row_done),
        .o_row_page (row_page)
    );

    dct_transpose_ram tm_i (
        .clk       (clk),
        .i_wr_en   (tm_we),
        .i_wr_addr (tm_wa),
        .i_wr_data (tm_wd),
        .i_rd_addr (tm_ra),
        .o_rd_data (tm_rd)
    );

    dct_col_stage col_i (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_row_done      (row_done),
        .i_row_page      (row_page),
        .o_rd_addr       (tm_ra),
        .i_rd_data       (tm_rd),
        .o_pre_first_out (o_pre_first_out),
        .o_dv            (o_dv),
        .o_coef          (o_coef)
    );

endmodule

`default_nettype wire

/* dv/dct_ref_model.svh */
`ifndef DCT_REF_MODEL_SVH
`define DCT_REF_MODEL_SVH
`default_nettype none

int     blk_pix [64];   // input block, stream order
longint blk_ref [64];   // expected output, index 8*u + v
longint vec_in  [8];    // one 1d input vector
longint vec_out [8];    // its eight frequencies

// wrap to a w-bit two's complement value
function automatic longint to_signed(longint v, int w);
    longint m;
    m = v & ((longint'(1) << w) - 1);
    if (m >= (longint'(1) << (w - 1))) begin
        m = m - (longint'(1) << w);
    end
    return m;
endfunction

// cos((2j+1)k pi/16) as a signed 16-bit magnitude, dc row scaled by C4
function automatic longint cos_coef(int k, int j);
    int     m;
    int     q;
    longint mag;
    m = ((2 * j + 1) * k) % 32;   // angle in units of pi/16
    q = m % 16;
    if (q > 8) begin
        q = 16 - q;               // fold into first quadrant
    end
    case (q)
        0:       mag = longint'(dct_pkg::C4);
        1:       mag = longint'(dct_pkg::S7);
        2:       mag = longint'(dct_pkg::S6);
        3:       mag = longint'(dct_pkg::C3);
        4:       mag = longint'(dct_pkg::C4);
        5:       mag = longint'(dct_pkg::S3);
        6:       mag = longint'(dct_pkg::C6);
        default: mag = longint'(dct_pkg::C7);
    endcase
    return (m > 8 && m < 24) ? -mag : mag;   // cosine negative in 2nd and 3rd quadrant
endfunction

// one 8-point pass, sign-magnitude products sliced before the adds
function automatic void dct_1d(int lsb, int pw, int sh, int ow);
    longint d;
    longint c;
    longint p;
    longint sum;
    bit     neg;
    for (int k = 0; k < 8; k++) begin
        sum = 0;
        for (int j = 0; j < 4; j++) begin
            d   = (k % 2 == 0) ? vec_in[j] + vec_in[7-j] : vec_in[j] - vec_in[7-j];
            c   = cos_coef(k, j);
            p   = (((d < 0) ? -d : d) * ((c < 0) ? -c : c)) >> lsb;
            p   = p & ((longint'(1) << pw) - 1);   // kept product bits
            neg = (d < 0) ^ (c < 0);
            sum = sum + to_signed(neg ? -p : p, pw);
        end
        vec_out[k] = to_signed((sum + (longint'(1) << (sh - 1))) >>> sh, ow);  // half up
    end
endfunction

// rows first, then columns of the row result, column-major output
function automatic void dct_block();
    longint rows [64];
    for (int r = 0; r < 8; r++) begin
        for (int c = 0; c < 8; c++) begin
            vec_in[c] = longint'(blk_pix[8*r+c]);
        end
        dct_1d(dct_pkg::ROW_PROD_LSB, dct_pkg::ROW_PROD_W, dct_pkg::ROW_RND_SH, dct_pkg::ROW_W);
        for (int u = 0; u < 8; u++) begin
            rows[8*r+u] = vec_out[u];
        end
    end
    for (int u = 0; u < 8; u++) begin
        for (int r = 0; r < 8; r++) begin
            vec_in[r] = rows[8*r+u];
        end
        dct_1d(dct_pkg::COL_PROD_LSB, dct_pkg::COL_PROD_W, dct_pkg::COL_RND_SH, dct_pkg::OUT_W);
        for (int v = 0; v < 8; v++) begin
            blk_ref[8*u+v] = vec_out[v];
        end
    end
endfunction

`default_nettype wire
`endif

/* dv/dct8x8_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dct8x8_tb;

    localparam int CLK_PER  = 40;
    localparam int RST_CYC  = 8;
    localparam int IDLE_CYC = 200;
    localparam int MAX_GAP  = 40;
    localparam int N_BLOCKS = 18;   // blocks sent over all tests
    localparam int LIMIT    = RST_CYC + IDLE_CYC + 200
                              + N_BLOCKS * (dct_pkg::BLK_SZ + MAX_GAP + dct_pkg::FIRST_OUT_LAT);

    logic                      clk;
    logic                      i_rst;
    logic                      i_start;
    logic [dct_pkg::PIX_W-1:0] i_pix;
    logic                      o_last_in;
    logic                      o_pre_first_out;
    logic                      o_dv;
    logic [dct_pkg::OUT_W-1:0] o_coef;

    int                        cyc = 0;   // rising edges so far
    int                        last_q [$];   // cycles where o_last_in is due
    int                        pre_q [$];    // cycles where o_pre_first_out is due
    int                        dv_q [$];     // first o_dv cycle of each block
    logic [dct_pkg::OUT_W-1:0] exp_q [$];    // expected coefficients in order
    int                        out_left = 0; // outputs left in the current run
    int                        out_idx = 0;  // outputs checked so far
    bit                        want_last;
    bit                        want_pre;
    logic [dct_pkg::OUT_W-1:0] exp_c;

    `include "dct_ref_model.svh"

    dct8x8_top dut_i (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_start         (i_start),
        .i_pix           (i_pix),
        .o_last_in       (o_last_in),
        .o_pre_first_out (o_pre_first_out),
        .o_dv            (o_dv),
        .o_coef          (o_coef)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PER / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // outputs are stable half a period after the edge
    always @(negedge clk) begin
        if (cyc >= LIMIT) begin
            abort_run($sformatf("Timeout at cycle %0d, %0d coefficients never came out",
                                cyc, exp_q.size()));
        end else if (!i_rst) begin
            if (i_start) begin   // schedule this block's strobes
                last_q.push_back(cyc + dct_pkg::BLK_SZ - 1);
                pre_q.push_back(cyc + dct_pkg::FIRST_OUT_LAT - 1);
                dv_q.push_back(cyc + dct_pkg::FIRST_OUT_LAT);
            end
            want_last = (last_q.size() != 0) && (last_q[0] == cyc);
            want_pre  = (pre_q.size() != 0) && (pre_q[0] == cyc);
            assert (o_last_in == want_last) else
                abort_run($sformatf("o_last_in was wrong in cycle %0d", cyc));
            assert (o_pre_first_out == want_pre) else
                abort_run($sformatf("o_pre_first_out was wrong in cycle %0d", cyc));
            if (want_last) void'(last_q.pop_front());
            if (want_pre) void'(pre_q.pop_front());
            if ((dv_q.size() != 0) && (dv_q[0] == cyc)) begin
                void'(dv_q.pop_front());
                out_left += dct_pkg::BLK_SZ;   // next block due now
            end
            assert (o_dv == (out_left != 0)) else
                abort_run($sformatf("o_dv was %0b in cycle %0d with %0d outputs due",
                                    o_dv, cyc, out_left));
            if (o_dv) begin
                exp_c = exp_q.pop_front();
                assert (o_coef === exp_c) else
                    abort_run($sformatf(
                        "Mismatch at %0t: block %0d coef %0d is %0d, expected %0d",
                        $time, out_idx / 64, out_idx % 64, $signed(o_coef), $signed(exp_c)));
                out_idx++;
                out_left--;
            end
        end
    end

    // model the block in blk_pix and queue the result before streaming it in
    task automatic send_block(input int gap);
        int unsigned junk;
        dct_block();
        for (int n = 0; n < dct_pkg::BLK_SZ; n++) begin
            exp_q.push_back(blk_ref[n][dct_pkg::OUT_W-1:0]);
        end
        for (int n = 0; n < dct_pkg::BLK_SZ; n++) begin
            @(posedge clk);
            i_start <= (n == 0);
            i_pix   <= blk_pix[n][dct_pkg::PIX_W-1:0];
        end
        repeat (gap) begin
            @(posedge clk);
            junk  = $urandom;
            i_pix <= junk[dct_pkg::PIX_W-1:0];   // ignored between blocks
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);   // o_dv must drop after the run
    endtask

    task automatic fill_random();
        for (int n = 0; n < dct_pkg::BLK_SZ; n++) begin
            blk_pix[n] = int'($urandom % 1024) - 512;
        end
    endtask

    task automatic idle_after_reset();
        repeat (IDLE_CYC) @(posedge clk);   // monitor expects all strobes low
    endtask

    task automatic constant_blocks();
        int vals [4] = '{0, 1, -77, 300};
        foreach (vals[i]) begin
            foreach (blk_pix[n]) blk_pix[n] = vals[i];
            send_block(0);
            assert (((blk_ref[0] > 0) == (vals[i] > 0))
                    && ((blk_ref[0] < 0) == (vals[i] < 0))) else
                abort_run($sformatf("dc term of constant block %0d has the wrong sign", vals[i]));
            for (int n = 1; n < dct_pkg::BLK_SZ; n++) begin
                assert (blk_ref[n] == 0) else
                    abort_run($sformatf("constant block %0d has ac term %0d set", vals[i], n));
            end
            wait_drained();
        end
    endtask

    task automatic one_random_block();
        fill_random();
        send_block(0);
        wait_drained();
    endtask

    task automatic back_to_back_blocks();
        repeat (4) begin
            fill_random();
            send_block(0);   // next start right after sample 63
        end
        wait_drained();
    endtask

    task automatic blocks_with_gaps();
        repeat (6) begin
            fill_random();
            send_block(int'($urandom % (MAX_GAP + 1)));
        end
        wait_drained();
    endtask

    task automatic extreme_blocks();
        foreach (blk_pix[n]) blk_pix[n] = 511;
        send_block(0);
        foreach (blk_pix[n]) blk_pix[n] = -512;
        send_block(0);
        foreach (blk_pix[n]) blk_pix[n] = ((n / 8 + n % 8) % 2 == 0) ? 511 : -512;  // checkerboard
        send_block(0);
        wait_drained();
    endtask

    initial begin
        void'($urandom(32'h08b6_52a5));
        i_rst   = 1'b1;
        i_start = 1'b0;
        i_pix   = '0;
        repeat (RST_CYC) @(posedge clk);
        i_rst <= 1'b0;
        idle_after_reset();
        constant_blocks();
        one_random_block();
        back_to_back_blocks();
        blocks_with_gaps();
        extreme_blocks();
        if (out_idx == N_BLOCKS * dct_pkg::BLK_SZ) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run($sformatf("only %0d of %0d coefficients were checked",
                                out_idx, N_BLOCKS * dct_pkg::BLK_SZ));
        end
    end

endmodule

`default_nettype wire

/* dct8x8.f */
+incdir+dv
common/dct_pkg.sv
dct_1d/dct_coef_rom.sv
dct_1d/dct_1d_datapath.sv
rtl/dct_transpose_ram.sv
rtl/dct_row_stage.sv
rtl/dct_col_stage.sv
rtl/dct8x8_top.sv
dv/dct8x8_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the dct8x8 testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f dct8x8.f \
    --top-module dct8x8_tb \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/Vdct8x8_tb 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^Simulation PASSED$"; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1
